/* verilog/decode_pkg.sv */
// decode stage types: widths, fetch-buffer entry, encoding enums,
// the RV32 instruction-format union and the micro-op struct
package decode_pkg;

        parameter int XLEN       = 32;
        parameter int REG_IDX_W  = 5;
        parameter int INST_BYTES = 4;

        typedef struct packed {
                logic [XLEN-1:0] pc;
                logic [31:0]     inst;
        } fb_entry_t;

        // issue queue and functional unit
        typedef enum logic [1:0] {
                IQ_NONE = 2'd0,
                IQ_INT  = 2'd1,
                IQ_MEM  = 2'd2
        } iq_code_t;

        typedef enum logic [1:0] {
                FU_NONE = 2'd0,
                FU_ALU  = 2'd1,
                FU_BR   = 2'd2,
                FU_MEM  = 2'd3
        } fu_code_t;

        typedef enum logic [3:0] {
                ALU_ADD  = 4'd0,
                ALU_SUB  = 4'd1,
                ALU_SLL  = 4'd2,
                ALU_SLT  = 4'd3,
                ALU_SLTU = 4'd4,
                ALU_XOR  = 4'd5,
                ALU_SRL  = 4'd6,
                ALU_SRA  = 4'd7,
                ALU_OR   = 4'd8,
                ALU_AND  = 4'd9
        } alu_type_t;

        typedef enum logic [2:0] {
                BR_JAL  = 3'd0,
                BR_JALR = 3'd1,
                BR_EQ   = 3'd2,
                BR_NE   = 3'd3,
                BR_LT   = 3'd4,
                BR_GE   = 3'd5,
                BR_LTU  = 3'd6,
                BR_GEU  = 3'd7
        } br_type_t;

        typedef enum logic [1:0] {
                MEM_LD  = 2'd0,
                MEM_LDU = 2'd1,
                MEM_ST  = 2'd2
        } mem_type_t;

        // same order as funct3[1:0] of loads and stores
        typedef enum logic [1:0] {
                MEM_BYTE = 2'd0,
                MEM_HALF = 2'd1,
                MEM_WORD = 2'd2
        } mem_size_t;

        typedef enum logic [2:0] {
                RS_INVALID   = 3'd0,
                RS_FROM_RF   = 3'd1,
                RS_FROM_IMM  = 3'd2,
                RS_FROM_PC   = 3'd3,
                RS_FROM_ZERO = 3'd4
        } rs_source_t;

        typedef enum logic [2:0] {
                IMM_NONE  = 3'd0,
                IMM_I     = 3'd1,
                IMM_S     = 3'd2,
                IMM_B     = 3'd3,
                IMM_U     = 3'd4,
                IMM_J     = 3'd5,
                IMM_SHAMT = 3'd6
        } imm_fmt_t;

        // one instruction word, one view per base format
        typedef union packed {
                struct packed {
                        logic [6:0] funct7;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [4:0] rd;
                        logic [6:0] opcode;
                } r;
                struct packed {
                        logic [11:0] imm_11_0;
                        logic [4:0]  rs1;
                        logic [2:0]  funct3;
                        logic [4:0]  rd;
                        logic [6:0]  opcode;
                } i;
                struct packed {
                        logic [6:0] imm_11_5;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [4:0] imm_4_0;
                        logic [6:0] opcode;
                } s;
                struct packed {
                        logic       imm_12;
                        logic [5:0] imm_10_5;
                        logic [4:0] rs2;
                        logic [4:0] rs1;
                        logic [2:0] funct3;
                        logic [3:0] imm_4_1;
                        logic       imm_11;
                        logic [6:0] opcode;
                } b;
                struct packed {
                        logic [19:0] imm_31_12;
                        logic [4:0]  rd;
                        logic [6:0]  opcode;
                } u;
                struct packed {
                        logic       imm_20;
                        logic [9:0] imm_10_1;
                        logic       imm_11;
                        logic [7:0] imm_19_12;
                        logic [4:0] rd;
                        logic [6:0] opcode;
                } j;
        } rv32_inst_u;

        typedef struct packed {
                logic                 valid;
                logic [XLEN-1:0]      pc;
                logic [XLEN-1:0]      npc;
                logic [31:0]          inst;
                iq_code_t             iq_code;
                fu_code_t             fu_code;
                alu_type_t            alu_type;
                br_type_t             br_type;
                mem_type_t            mem_type;
                mem_size_t            mem_size;
                logic [XLEN-1:0]      imm;
                rs_source_t           rs1_source;
                logic [REG_IDX_W-1:0] rs1_index;
                rs_source_t           rs2_source;
                logic [REG_IDX_W-1:0] rs2_index;
                logic [REG_IDX_W-1:0] rd_index;
                logic                 rd_valid;
                logic                 pred_taken;
        } micro_op_t;

endpackage

/* verilog/imm_gen.sv */
// immediate generator for the RV32 formats I, S, B, U, J and shift amount
module imm_gen (
        input  decode_pkg::rv32_inst_u      inst,
        input  decode_pkg::imm_fmt_t        fmt,
        output logic [decode_pkg::XLEN-1:0] imm
);

        localparam int XLEN = decode_pkg::XLEN;

        always_comb begin
                case (fmt)
                decode_pkg::IMM_I: begin
                        imm = {{(XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
                end
                decode_pkg::IMM_S: begin
                        imm = {{(XLEN-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5,
                               inst.s.imm_4_0};
                end
                decode_pkg::IMM_B: begin
                        // bit 0 is always zero for branch offsets
                        imm = {{(XLEN-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                               inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
                end
                decode_pkg::IMM_U: begin
                        imm = {inst.u.imm_31_12, 12'b0};
                end
                decode_pkg::IMM_J: begin
                        imm = {{(XLEN-21){inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
                               inst.j.imm_11, inst.j.imm_10_1, 1'b0};
                end
                decode_pkg::IMM_SHAMT: begin
                        // shamt sits in the low five immediate bits
                        imm = {{(XLEN-5){1'b0}}, inst.i.imm_11_0[4:0]};
                end
                default: begin
                        imm = '0;
                end
                endcase
        end

endmodule

/* verilog/decode_slot.sv */
// single-slot RV32I decoder: one fetch-buffer entry to one micro-op,
// unknown encodings and empty slots give an all-zero micro-op
module decode_slot (
        input  decode_pkg::fb_entry_t entry,
        input  logic                  valid,
        output decode_pkg::micro_op_t uop
);

        localparam logic [6:0] OPC_LUI    = 7'b0110111;
        localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
        localparam logic [6:0] OPC_JAL    = 7'b1101111;
        localparam logic [6:0] OPC_JALR   = 7'b1100111;
        localparam logic [6:0] OPC_BRANCH = 7'b1100011;
        localparam logic [6:0] OPC_LOAD   = 7'b0000011;
        localparam logic [6:0] OPC_STORE  = 7'b0100011;
        localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
        localparam logic [6:0] OPC_OP     = 7'b0110011;

        decode_pkg::rv32_inst_u      inst;
        decode_pkg::imm_fmt_t        imm_fmt;
        logic [decode_pkg::XLEN-1:0] imm;
        logic                        known;
        decode_pkg::micro_op_t       dec;

        // alt selects SUB over ADD and SRA over SRL
        function automatic decode_pkg::alu_type_t alu_sel(input logic [2:0] funct3,
                                                          input logic       alt);
                decode_pkg::alu_type_t op;
                case (funct3)
                3'b000:  op = alt ? decode_pkg::ALU_SUB : decode_pkg::ALU_ADD;
                3'b001:  op = decode_pkg::ALU_SLL;
                3'b010:  op = decode_pkg::ALU_SLT;
                3'b011:  op = decode_pkg::ALU_SLTU;
                3'b100:  op = decode_pkg::ALU_XOR;
                3'b101:  op = alt ? decode_pkg::ALU_SRA : decode_pkg::ALU_SRL;
                3'b110:  op = decode_pkg::ALU_OR;
                default: op = decode_pkg::ALU_AND;
                endcase
                return op;
        endfunction

        assign inst = entry.inst;

        imm_gen u_imm_gen (
                .inst (inst),
                .fmt  (imm_fmt),
                .imm  (imm)
        );

        always_comb begin
                dec        = '0;
                known      = 1'b1;
                imm_fmt    = decode_pkg::IMM_NONE;
                dec.valid  = 1'b1;
                dec.pc     = entry.pc;
                dec.npc    = entry.pc + decode_pkg::INST_BYTES;
                dec.inst   = entry.inst;
                dec.iq_code = decode_pkg::IQ_INT;
                dec.fu_code = decode_pkg::FU_ALU;
                dec.rs1_source = decode_pkg::RS_FROM_RF;
                dec.rs1_index  = inst.r.rs1;
                case (inst.r.opcode)
                OPC_LUI, OPC_AUIPC: begin
                        imm_fmt        = decode_pkg::IMM_U;
                        dec.rs1_source = (inst.r.opcode == OPC_LUI) ?
                                         decode_pkg::RS_FROM_ZERO : decode_pkg::RS_FROM_PC;
                        dec.rs1_index  = '0;
                        dec.rs2_source = decode_pkg::RS_FROM_IMM;
                        dec.rd_index   = inst.u.rd;
                end
                OPC_JAL: begin
                        imm_fmt        = decode_pkg::IMM_J;
                        dec.fu_code    = decode_pkg::FU_BR;
                        dec.br_type    = decode_pkg::BR_JAL;
                        dec.rs1_source = decode_pkg::RS_FROM_PC;
                        dec.rs1_index  = '0;
                        dec.rs2_source = decode_pkg::RS_FROM_IMM;
                        dec.rd_index   = inst.j.rd;
                        dec.pred_taken = 1'b1;
                end
                OPC_JALR: begin
                        known          = (inst.i.funct3 == 3'b000);
                        imm_fmt        = decode_pkg::IMM_I;
                        dec.fu_code    = decode_pkg::FU_BR;
                        dec.br_type    = decode_pkg::BR_JALR;
                        dec.rs2_source = decode_pkg::RS_FROM_IMM;
                        dec.rd_index   = inst.i.rd;
                end
                OPC_BRANCH: begin
                        imm_fmt        = decode_pkg::IMM_B;
                        dec.fu_code    = decode_pkg::FU_BR;
                        dec.rs2_source = decode_pkg::RS_FROM_RF;
                        dec.rs2_index  = inst.b.rs2;
                        case (inst.b.funct3)
                        3'b000:  dec.br_type = decode_pkg::BR_EQ;
                        3'b001:  dec.br_type = decode_pkg::BR_NE;
                        3'b100:  dec.br_type = decode_pkg::BR_LT;
                        3'b101:  dec.br_type = decode_pkg::BR_GE;
                        3'b110:  dec.br_type = decode_pkg::BR_LTU;
                        3'b111:  dec.br_type = decode_pkg::BR_GEU;
                        default: known = 1'b0;
                        endcase
                end
                OPC_LOAD, OPC_STORE: begin
                        dec.iq_code  = decode_pkg::IQ_MEM;
                        dec.fu_code  = decode_pkg::FU_MEM;
                        dec.mem_size = decode_pkg::mem_size_t'(inst.i.funct3[1:0]);
                        // no word-size unsigned load, no unsigned stores
                        known = (inst.i.funct3[1:0] != 2'b11) &&
                                !(inst.i.funct3[2] && (inst.i.funct3[1] ||
                                                       inst.r.opcode == OPC_STORE));
                        if (inst.r.opcode == OPC_LOAD) begin
                                imm_fmt        = decode_pkg::IMM_I;
                                dec.mem_type   = inst.i.funct3[2] ?
                                                 decode_pkg::MEM_LDU : decode_pkg::MEM_LD;
                                dec.rs2_source = decode_pkg::RS_FROM_IMM;
                                dec.rd_index   = inst.i.rd;
                        end else begin
                                imm_fmt        = decode_pkg::IMM_S;
                                dec.mem_type   = decode_pkg::MEM_ST;
                                dec.rs2_source = decode_pkg::RS_FROM_RF;
                                dec.rs2_index  = inst.s.rs2;
                        end
                end
                OPC_OP_IMM: begin
                        imm_fmt        = (inst.i.funct3[1:0] == 2'b01) ?
                                         decode_pkg::IMM_SHAMT : decode_pkg::IMM_I;
                        dec.alu_type   = alu_sel(inst.i.funct3, inst.i.funct3 == 3'b101 &&
                                                 inst.r.funct7[5]);
                        dec.rs2_source = decode_pkg::RS_FROM_IMM;
                        dec.rd_index   = inst.i.rd;
                        if (inst.i.funct3 == 3'b001)
                                known = (inst.r.funct7 == 7'h00);
                        else if (inst.i.funct3 == 3'b101)
                                known = (inst.r.funct7 == 7'h00) || (inst.r.funct7 == 7'h20);
                end
                OPC_OP: begin
                        dec.alu_type   = alu_sel(inst.r.funct3, inst.r.funct7[5]);
                        dec.rs2_source = decode_pkg::RS_FROM_RF;
                        dec.rs2_index  = inst.r.rs2;
                        dec.rd_index   = inst.r.rd;
                        known = (inst.r.funct7 == 7'h00) ||
                                (inst.r.funct7 == 7'h20 &&
                                 (inst.r.funct3 == 3'b000 || inst.r.funct3 == 3'b101));
                end
                default: begin
                        known = 1'b0;
                end
                endcase
                // x0 writes are dropped
                dec.rd_valid = (dec.rd_index != '0);
        end

        always_comb begin
                uop = '0;
                if (valid && known) begin
                        uop     = dec;
                        uop.imm = imm;
                end
        end

endmodule

/* verilog/uop_reg.sv */
// output register for a decoded group of micro-ops
module uop_reg #(
        parameter int DECODE_WIDTH = 2
) (
        input  logic                                     clock,
        input  logic                                     rst_n,
        input  decode_pkg::micro_op_t [DECODE_WIDTH-1:0] d,
        output decode_pkg::micro_op_t [DECODE_WIDTH-1:0] q
);

        // whole group moves together, one group per cycle
        always_ff @(posedge clock or negedge rst_n) begin
                if (!rst_n) begin
                        q <= '0;
                end else begin
                        q <= d;
                end
        end

endmodule

/* verilog/inst_decode.sv */
// decode stage top: DECODE_WIDTH slot decoders feeding one output register,
// fixed latency of one cycle
module inst_decode #(
        parameter int DECODE_WIDTH = 2
) (
        input  logic                                     clock,
        input  logic                                     rst_n,
        input  decode_pkg::fb_entry_t [DECODE_WIDTH-1:0] insts,
        input  logic                  [DECODE_WIDTH-1:0] insts_valid,
        output decode_pkg::micro_op_t [DECODE_WIDTH-1:0] uops
);

        decode_pkg::micro_op_t [DECODE_WIDTH-1:0] dec_uops;

        // one decoder per fetch-buffer slot
        for (genvar g = 0; g < DECODE_WIDTH; g++) begin : g_slot
                decode_slot u_decode_slot (
                        .entry (insts[g]),
                        .valid (insts_valid[g]),
                        .uop   (dec_uops[g])
                );
        end

        uop_reg #(
                .DECODE_WIDTH (DECODE_WIDTH)
        ) u_uop_reg (
                .clock (clock),
                .rst_n (rst_n),
                .d     (dec_uops),
                .q     (uops)
        );

endmodule

/* include/decode_checks.svh */
// compare tasks for decoded micro-ops: field by field check of a
// decoded slot and the all-zero check of an empty slot
`ifndef DECODE_CHECKS_SVH
`define DECODE_CHECKS_SVH

task automatic compare_field(input string field, input int slot,
                             input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
                $display("FAIL uops[%0d].%s expected 0x%h got 0x%h", slot, field, exp, act);
                stop_with_failure();
        end
endtask

task automatic check_uop(input decode_pkg::micro_op_t exp, input decode_pkg::micro_op_t act,
                         input int slot);
        compare_field("valid", slot, 32'(exp.valid), 32'(act.valid));
        compare_field("pc", slot, exp.pc, act.pc);
        compare_field("npc", slot, exp.npc, act.npc);
        compare_field("inst", slot, exp.inst, act.inst);
        compare_field("iq_code", slot, 32'(exp.iq_code), 32'(act.iq_code));
        compare_field("fu_code", slot, 32'(exp.fu_code), 32'(act.fu_code));
        compare_field("alu_type", slot, 32'(exp.alu_type), 32'(act.alu_type));
        compare_field("br_type", slot, 32'(exp.br_type), 32'(act.br_type));
        compare_field("mem_type", slot, 32'(exp.mem_type), 32'(act.mem_type));
        compare_field("mem_size", slot, 32'(exp.mem_size), 32'(act.mem_size));
        compare_field("imm", slot, exp.imm, act.imm);
        compare_field("rs1_source", slot, 32'(exp.rs1_source), 32'(act.rs1_source));
        compare_field("rs1_index", slot, 32'(exp.rs1_index), 32'(act.rs1_index));
        compare_field("rs2_source", slot, 32'(exp.rs2_source), 32'(act.rs2_source));
        compare_field("rs2_index", slot, 32'(exp.rs2_index), 32'(act.rs2_index));
        compare_field("rd_index", slot, 32'(exp.rd_index), 32'(act.rd_index));
        compare_field("rd_valid", slot, 32'(exp.rd_valid), 32'(act.rd_valid));
        compare_field("pred_taken", slot, 32'(exp.pred_taken), 32'(act.pred_taken));
endtask

// empty slot or unknown encoding
task automatic check_bubble(input decode_pkg::micro_op_t act, input int slot);
        decode_pkg::micro_op_t zero;
        zero = '0;
        if (act !== zero) begin
                $display("FAIL uops[%0d] expected 0x%h got 0x%h", slot, zero, act);
                stop_with_failure();
        end
endtask

`endif

/* bench/tb_inst_decode.sv */
// testbench for the decode stage: clock and reset, vector file,
// LFSR bubble insertion, checks one cycle later and the watchdog
module tb_inst_decode;

        localparam int DECODE_WIDTH = 2;
        localparam int NUM_VECS     = 24;
        localparam int VEC_COLS     = 16;
        localparam int CLK_PERIOD   = 8;
        // two passes over the vectors, plus reset and drain slack
        localparam int WATCHDOG_CYCLES = 2 * NUM_VECS + 10;

        logic                                     clock;
        logic                                     rst_n;
        decode_pkg::fb_entry_t [DECODE_WIDTH-1:0] insts;
        logic                  [DECODE_WIDTH-1:0] insts_valid;
        decode_pkg::micro_op_t [DECODE_WIDTH-1:0] uops;

        logic [31:0]           vec_mem [0:NUM_VECS*VEC_COLS-1];
        decode_pkg::micro_op_t exp_q[$];
        logic [31:0]           lfsr;

        inst_decode #(
                .DECODE_WIDTH (DECODE_WIDTH)
        ) i_inst_decode (
                .clock       (clock),
                .rst_n       (rst_n),
                .insts       (insts),
                .insts_valid (insts_valid),
                .uops        (uops)
        );

        task automatic stop_with_failure();
                $display("TEST RESULT: FAIL");
                $fatal(1);
        endtask

        `include "decode_checks.svh"

        // taps 32, 22, 2, 1
        function automatic logic [31:0] lfsr_next(input logic [31:0] s);
                logic fb;
                fb = s[31] ^ s[21] ^ s[1] ^ s[0];
                return {s[30:0], fb};
        endfunction

        // columns: pc inst iq fu alu br mem_type mem_size imm rs1 rs2 rd
        function automatic decode_pkg::micro_op_t expected_uop(input int idx);
                decode_pkg::micro_op_t u;
                int                    b;
                b = idx * VEC_COLS;
                u = '0;
                // iq of zero marks an encoding that must decode to nothing
                if (vec_mem[b+2] != 32'h0) begin
                        u.valid      = 1'b1;
                        u.pc         = vec_mem[b];
                        u.npc        = vec_mem[b] + 32'd4;
                        u.inst       = vec_mem[b+1];
                        u.iq_code    = decode_pkg::iq_code_t'(vec_mem[b+2][1:0]);
                        u.fu_code    = decode_pkg::fu_code_t'(vec_mem[b+3][1:0]);
                        u.alu_type   = decode_pkg::alu_type_t'(vec_mem[b+4][3:0]);
                        u.br_type    = decode_pkg::br_type_t'(vec_mem[b+5][2:0]);
                        u.mem_type   = decode_pkg::mem_type_t'(vec_mem[b+6][1:0]);
                        u.mem_size   = decode_pkg::mem_size_t'(vec_mem[b+7][1:0]);
                        u.imm        = vec_mem[b+8];
                        u.rs1_source = decode_pkg::rs_source_t'(vec_mem[b+9][2:0]);
                        u.rs1_index  = vec_mem[b+10][4:0];
                        u.rs2_source = decode_pkg::rs_source_t'(vec_mem[b+11][2:0]);
                        u.rs2_index  = vec_mem[b+12][4:0];
                        u.rd_index   = vec_mem[b+13][4:0];
                        u.rd_valid   = vec_mem[b+14][0];
                        u.pred_taken = vec_mem[b+15][0];
                end
                return u;
        endfunction

        task automatic check_group();
                decode_pkg::micro_op_t exp;
                for (int s = 0; s < DECODE_WIDTH; s++) begin
                        exp = exp_q.pop_front();
                        if (exp.valid)
                                check_uop(exp, uops[s], s);
                        else
                                check_bubble(uops[s], s);
                end
        endtask

        initial begin
                clock = 1'b0;
                forever #(CLK_PERIOD / 2) clock = ~clock;
        end

        initial begin : watchdog
                repeat (WATCHDOG_CYCLES) @(posedge clock);
                $display("timeout: the decode run did not finish in %0d cycles",
                         WATCHDOG_CYCLES);
                stop_with_failure();
        end

        initial begin : main
                decode_pkg::fb_entry_t [DECODE_WIDTH-1:0] grp;
                logic                  [DECODE_WIDTH-1:0] vld;
                int                                       idx;
                rst_n       = 1'b0;
                insts       = '0;
                insts_valid = '0;
                lfsr        = 32'h1f0a133c;
                $readmemh("bench/decode_vectors.hex", vec_mem);
                if ($isunknown(vec_mem[0]) || vec_mem[0] == 32'h0) begin
                        $display("the vector file bench/decode_vectors.hex could not be read");
                        stop_with_failure();
                end
                // a valid group held during reset must not reach uops
                for (int s = 0; s < DECODE_WIDTH; s++) begin
                        grp[s].pc   = vec_mem[s*VEC_COLS];
                        grp[s].inst = vec_mem[s*VEC_COLS+1];
                end
                insts       = grp;
                insts_valid = '1;
                repeat (2) @(posedge clock);
                rst_n <= 1'b1;
                @(negedge clock);
                for (int s = 0; s < DECODE_WIDTH; s++)
                        check_bubble(uops[s], s);
                // first pass all slots valid, second pass with random bubbles
                for (int pass = 0; pass < 2; pass++) begin
                        for (int g = 0; g < NUM_VECS; g += DECODE_WIDTH) begin
                                @(posedge clock);
                                for (int s = 0; s < DECODE_WIDTH; s++) begin
                                        idx         = g + s;
                                        grp[s].pc   = vec_mem[idx*VEC_COLS];
                                        grp[s].inst = vec_mem[idx*VEC_COLS+1];
                                        vld[s]      = 1'b1;
                                        if (pass == 1) begin
                                                lfsr   = lfsr_next(lfsr);
                                                vld[s] = ~lfsr[0];
                                        end
                                        if (vld[s])
                                                exp_q.push_back(expected_uop(idx));
                                        else
                                                exp_q.push_back('0);
                                end
                                insts       <= grp;
                                insts_valid <= vld;
                                @(negedge clock);
                                if (exp_q.size() > DECODE_WIDTH)
                                        check_group();
                        end
                end
                @(posedge clock);
                insts_valid <= '0;
                @(negedge clock);
                check_group();
                $display("TEST RESULT: PASS");
                $finish;
        end

endmodule

/* bench/decode_vectors.hex */
// pc inst iq fu alu br mem_type mem_size imm rs1_src rs1 rs2_src rs2 rd rd_valid pred_taken
// iq 0 means the encoding is unknown and the slot must come out all zero
00001000 123452b7 1 1 0 0 0 0 12345000 4 00 2 00 05 1 0
00001004 fffff517 1 1 0 0 0 0 fffff000 3 00 2 00 0a 1 0
00001008 010000ef 1 2 0 0 0 0 00000010 3 00 2 00 01 1 1
0000100c ffdff06f 1 2 0 0 0 0 fffffffc 3 00 2 00 00 0 1
00001010 008100e7 1 2 0 1 0 0 00000008 1 02 2 00 01 1 0
00001014 00208463 1 2 0 2 0 0 00000008 1 01 1 02 00 0 0
00001018 fe419ce3 1 2 0 3 0 0 fffffff8 1 03 1 04 00 0 0
0000101c 0062c863 1 2 0 4 0 0 00000010 1 05 1 06 00 0 0
00001020 0083f0e3 1 2 0 7 0 0 00000800 1 07 1 08 00 0 0
00001024 fff60583 2 3 0 0 0 0 ffffffff 1 0c 2 00 0b 1 0
00001028 00475683 2 3 0 0 1 1 00000004 1 0e 2 00 0d 1 0
0000102c 7ff82783 2 3 0 0 0 2 000007ff 1 10 2 00 0f 1 0
00001030 01192623 2 3 0 0 2 2 0000000c 1 12 1 11 00 0 0
00001034 ff3a0023 2 3 0 0 2 0 ffffffe0 1 14 1 13 00 0 0
00001038 00000013 1 1 0 0 0 0 00000000 1 00 2 00 00 0 0
0000103c fffb4a93 1 1 5 0 0 0 ffffffff 1 16 2 00 15 1 0
00001040 007c1b93 1 1 2 0 0 0 00000007 1 18 2 00 17 1 0
00001044 41fd5c93 1 1 7 0 0 0 0000001f 1 1a 2 00 19 1 0
00001048 064e3d93 1 1 4 0 0 0 00000064 1 1c 2 00 1b 1 0
0000104c 41ff0eb3 1 1 1 0 0 0 00000000 1 1e 1 1f 1d 1 0
00001050 003170b3 1 1 9 0 0 0 00000000 1 02 1 03 01 1 0
00001054 0062d233 1 1 6 0 0 0 00000000 1 05 1 06 04 1 0
00001058 0ff0000f 0 0 0 0 0 0 00000000 0 00 0 00 00 0 0
0000105c 00012087 0 0 0 0 0 0 00000000 0 00 0 00 00 0 0

/* list.f */
+incdir+include
verilog/decode_pkg.sv
verilog/imm_gen.sv
verilog/decode_slot.sv
verilog/uop_reg.sv
verilog/inst_decode.sv
bench/tb_inst_decode.sv

/* run.sh */
#!/usr/bin/env bash
# builds the decode stage testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"
verilator --binary --timing -j 0 --top-module tb_inst_decode -f list.f -o sim_inst_decode
./obj_dir/sim_inst_decode
